// ==== rtl/spi_bridge_pkg.sv ====
`default_nettype none

package spi_bridge_pkg;

    // Default bus geometry, top level may override
    localparam int WB_DATA_WIDTH_DEF = 8;   // Serial framing is byte wide
    localparam int WB_ADDR_WIDTH_DEF = 20;  // 1 MiB system memory

    // Command byte layout
    localparam int CMD_WRITE_BIT = 7;       // 1 = write, 0 = read
    localparam int CMD_ADDR_BIT  = 6;       // 1 = two address bytes follow

    // Serial-domain command decoder
    // Bit 2 is set only in CMD_VALID so it can be synchronized on its own
    typedef enum logic [2:0] {
        CMD_WAIT_CMD     = 3'b000,  // Expecting command byte
        CMD_WAIT_DATA    = 3'b001,  // Write pending, expecting data byte
        CMD_WAIT_ADDR_HI = 3'b010,  // Expecting address bits 15..8
        CMD_WAIT_ADDR_LO = 3'b011,  // Expecting address bits 7..0
        CMD_VALID        = 3'b100   // Command complete, held until CS rises
    } cmd_state_e;

    // System-domain bus state
    // Bit 0 drives stall, bit 1 drives the Wishbone cycle
    typedef enum logic [1:0] {
        BUS_READY      = 2'b00,     // Idle, host may start a transfer
        BUS_RECEIVING  = 2'b01,     // CS low, command still arriving
        BUS_PROCESSING = 2'b11      // Bus access in flight
    } bus_state_e;

endpackage

`default_nettype wire

// ==== rtl/sync2_edge_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync2_edge_detect #(
    parameter logic RESET_VALUE = 1'b0  // Idle level of the incoming signal
) (
    input  logic spi_cs_ni,     // System clock
    input  logic spi_sck_i,     // Async reset, active high
    input  logic data_i,        // Asynchronous level
    output logic data_o,        // Synchronized level
    output logic pe_o,          // One-cycle pulse on rising edge
    output logic ne_o           // One-cycle pulse on falling edge
);

    logic meta_q;   // First stage, may go metastable
    logic sync_q;   // Second stage, safe to use
    logic prev_q;   // Copy of sync_q one cycle older

    // Two-flop synchronizer plus history flop
    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            meta_q <= RESET_VALUE;
            sync_q <= RESET_VALUE;
            prev_q <= RESET_VALUE;
            pe_o   <= 1'b0;
            ne_o   <= 1'b0;
        end else begin
            meta_q <= data_i;
            sync_q <= meta_q;
            prev_q <= sync_q;
            pe_o   <= sync_q & ~prev_q;    // Registered so pulse lands 3 cycles after input
            ne_o   <= ~sync_q & prev_q;
        end
    end

    assign data_o = sync_q;

endmodule

`default_nettype wire

// ==== rtl/spi_byte_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

// Mode 0 byte shifter, runs entirely on the host's serial clock
module spi_byte_shifter (
    input  logic       mcu_cs_ni,   // Chip select, high clears the bit count
    input  logic       mcu_sck_i,   // Serial clock from host
    input  logic       mcu_sdi_i,   // Host to bridge
    output logic       mcu_sdo_o,   // Bridge to host
    input  logic [7:0] tx_byte_i,   // Byte to send, must be stable during bit 0
    output logic [7:0] rx_byte_o,   // Full byte while byte_done_o is high
    output logic       byte_done_o  // High across the 8th rising edge of a byte
);

    logic [2:0] bit_cnt;    // Rising edges seen in current byte
    logic [6:0] rx_sr;      // First seven bits received, MSB first
    logic [6:0] tx_sr;      // Remaining bits to send after the MSB

    // Bit counter
    // Wraps every byte, held at zero while deselected
    always_ff @(posedge mcu_sck_i or posedge mcu_cs_ni) begin
        if (mcu_cs_ni) begin
            bit_cnt <= 3'd0;
        end else begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    // Receive side samples on the rising edge
    always_ff @(posedge mcu_sck_i) begin
        rx_sr <= {rx_sr[5:0], mcu_sdi_i};
    end

    // Eighth bit is taken straight from the pin so the decoder
    // sees the whole byte on the same edge that completes it
    assign rx_byte_o   = {rx_sr, mcu_sdi_i};
    assign byte_done_o = (bit_cnt == 3'd7);

    // Transmit side changes on the falling edge
    // First falling edge of a byte grabs the low seven bits of tx_byte_i,
    // later ones shift toward the MSB
    always_ff @(negedge mcu_sck_i) begin
        if (bit_cnt == 3'd1) begin
            tx_sr <= tx_byte_i[6:0];
        end else begin
            tx_sr <= {tx_sr[5:0], 1'b0};
        end
    end

    // In bit 0 there is no falling edge yet after CS drops
    // so the MSB comes straight from tx_byte_i
    assign mcu_sdo_o = (bit_cnt == 3'd0) ? tx_byte_i[7] : tx_sr[6];

endmodule

`default_nettype wire

// ==== rtl/spi_bus_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_bus_controller #(
    parameter int WB_DATA_WIDTH = spi_bridge_pkg::WB_DATA_WIDTH_DEF,
    parameter int WB_ADDR_WIDTH = spi_bridge_pkg::WB_ADDR_WIDTH_DEF
) (
    input  logic                     spi_cs_ni,  // System clock
    input  logic                     spi_sck_i,  // Async reset, active high

    // Host SPI link
    input  logic                     mcu_cs_ni,
    input  logic                     mcu_sck_i,
    input  logic                     mcu_sdi_i,
    output logic                     mcu_sdo_o,
    output logic                     stall_o,    // Host must wait while high

    // Wishbone B4 pipelined master
    output logic [WB_ADDR_WIDTH-1:0] wb_addr_o,  // Held in serial domain, stable once valid
    output logic [WB_DATA_WIDTH-1:0] wb_data_o,  // Write data
    input  logic [WB_DATA_WIDTH-1:0] wb_data_i,  // Read data, taken on ack
    output logic                     wb_we_o,    // 1 = write
    output logic                     wb_cyc_o,
    output logic                     wb_stb_o,
    input  logic                     wb_ack_i
);

    // Serial framing is one byte per data transfer, upper address nibble sits in the command
    if (WB_DATA_WIDTH != 8) begin : g_bad_data_width
        $error("spi_bus_controller needs WB_DATA_WIDTH of 8");
    end
    if (WB_ADDR_WIDTH < 17 || WB_ADDR_WIDTH > 24) begin : g_bad_addr_width
        $error("spi_bus_controller needs WB_ADDR_WIDTH from 17 to 24");
    end

    logic [7:0]               rx_byte;      // Byte from host
    logic                     byte_done;    // rx_byte complete on this SCK edge
    logic [WB_DATA_WIDTH-1:0] tx_byte;      // Read result returned in next transfer
    logic [7:0]               addr_hi_ext;  // Command nibble widened for any address width

    spi_bridge_pkg::cmd_state_e cmd_state;  // Serial-domain decoder
    spi_bridge_pkg::bus_state_e bus_state;  // System-domain bus FSM

    spi_byte_shifter spi_byte_shifter_inst (
        .mcu_cs_ni  (mcu_cs_ni),
        .mcu_sck_i  (mcu_sck_i),
        .mcu_sdi_i  (mcu_sdi_i),
        .mcu_sdo_o  (mcu_sdo_o),
        .tx_byte_i  (tx_byte),
        .rx_byte_o  (rx_byte),
        .byte_done_o(byte_done)
    );

    assign addr_hi_ext = {4'h0, rx_byte[3:0]};  // Bits 3..0 are address 19..16

    // Decoder state, restarts whenever the host deselects
    always_ff @(posedge mcu_sck_i or posedge mcu_cs_ni) begin
        if (mcu_cs_ni) begin
            cmd_state <= spi_bridge_pkg::CMD_WAIT_CMD;
        end else if (byte_done) begin
            unique case (cmd_state)
                spi_bridge_pkg::CMD_WAIT_CMD: begin
                    if (rx_byte[spi_bridge_pkg::CMD_ADDR_BIT]) begin
                        cmd_state <= spi_bridge_pkg::CMD_WAIT_ADDR_HI;
                    end else if (rx_byte[spi_bridge_pkg::CMD_WRITE_BIT]) begin
                        cmd_state <= spi_bridge_pkg::CMD_WAIT_DATA;  // Auto-increment write
                    end else begin
                        cmd_state <= spi_bridge_pkg::CMD_VALID;      // Auto-increment read
                    end
                end
                spi_bridge_pkg::CMD_WAIT_ADDR_HI: cmd_state <= spi_bridge_pkg::CMD_WAIT_ADDR_LO;
                spi_bridge_pkg::CMD_WAIT_ADDR_LO: begin
                    cmd_state <= wb_we_o ? spi_bridge_pkg::CMD_WAIT_DATA
                                         : spi_bridge_pkg::CMD_VALID;
                end
                spi_bridge_pkg::CMD_WAIT_DATA: cmd_state <= spi_bridge_pkg::CMD_VALID;
                spi_bridge_pkg::CMD_VALID:     cmd_state <= spi_bridge_pkg::CMD_VALID;  // Extra bytes ignored
                default:                       cmd_state <= spi_bridge_pkg::CMD_WAIT_CMD;
            endcase
        end
    end

    // Command fields, kept across transfers so auto-increment can reuse the address
    always_ff @(posedge mcu_sck_i) begin
        if (byte_done) begin
            unique case (cmd_state)
                spi_bridge_pkg::CMD_WAIT_CMD: begin
                    wb_we_o <= rx_byte[spi_bridge_pkg::CMD_WRITE_BIT];
                    if (rx_byte[spi_bridge_pkg::CMD_ADDR_BIT]) begin
                        wb_addr_o[WB_ADDR_WIDTH-1:16] <= addr_hi_ext[WB_ADDR_WIDTH-17:0];
                    end else begin
                        wb_addr_o <= wb_addr_o + WB_ADDR_WIDTH'(1);  // Previous address plus one
                    end
                end
                spi_bridge_pkg::CMD_WAIT_ADDR_HI: wb_addr_o[15:8] <= rx_byte;
                spi_bridge_pkg::CMD_WAIT_ADDR_LO: wb_addr_o[7:0]  <= rx_byte;
                spi_bridge_pkg::CMD_WAIT_DATA:    wb_data_o       <= rx_byte;
                default: ;  // Nothing to capture once valid
            endcase
        end
    end

    // Crossing into the system clock
    logic cs_fall_pulse;    // Host selected
    logic cs_rise_pulse;    // Host deselected, also aborts
    logic cmd_valid_pulse;  // Decoder reached CMD_VALID

    sync2_edge_detect #(
        .RESET_VALUE(1'b1)  // CS idles high
    ) sync_cs_inst (
        .spi_cs_ni(spi_cs_ni),
        .spi_sck_i(spi_sck_i),
        .data_i   (mcu_cs_ni),
        .data_o   (),
        .pe_o     (cs_rise_pulse),
        .ne_o     (cs_fall_pulse)
    );

    sync2_edge_detect #(
        .RESET_VALUE(1'b0)
    ) sync_valid_inst (
        .spi_cs_ni(spi_cs_ni),
        .spi_sck_i(spi_sck_i),
        .data_i   (cmd_state[2]),   // Set only in CMD_VALID
        .data_o   (),
        .pe_o     (cmd_valid_pulse),
        .ne_o     ()
    );

    // Bus FSM drives stall and cycle straight from its state bits
    assign stall_o  = bus_state[0];
    assign wb_cyc_o = bus_state[1];

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            bus_state <= spi_bridge_pkg::BUS_READY;
            wb_stb_o  <= 1'b0;
            tx_byte   <= '0;    // Host reads zero until the first read completes
        end else if (cs_rise_pulse && bus_state != spi_bridge_pkg::BUS_PROCESSING) begin
            bus_state <= spi_bridge_pkg::BUS_READY;  // Deselect ends or aborts the command
            wb_stb_o  <= 1'b0;
        end else begin
            unique case (bus_state)
                spi_bridge_pkg::BUS_READY: begin
                    if (cs_fall_pulse) begin
                        bus_state <= spi_bridge_pkg::BUS_RECEIVING;
                    end
                end
                spi_bridge_pkg::BUS_RECEIVING: begin
                    if (cmd_valid_pulse) begin
                        wb_stb_o  <= 1'b1;  // Single strobe for the single access
                        bus_state <= spi_bridge_pkg::BUS_PROCESSING;
                    end
                end
                spi_bridge_pkg::BUS_PROCESSING: begin
                    wb_stb_o <= 1'b0;
                    if (wb_ack_i) begin     // Cycle stays open until the target answers
                        if (!wb_we_o) begin
                            tx_byte <= wb_data_i;   // Only a read result goes back to the host
                        end
                        bus_state <= spi_bridge_pkg::BUS_READY;
                    end
                end
                default: bus_state <= spi_bridge_pkg::BUS_READY;
            endcase
        end
    end

    // Strobe only inside an open cycle
    assert property (@(posedge spi_cs_ni) disable iff (spi_sck_i)
        wb_stb_o |-> wb_cyc_o);

    // One request per command, strobe never repeats
    assert property (@(posedge spi_cs_ni) disable iff (spi_sck_i)
        wb_stb_o |=> !wb_stb_o);

endmodule

`default_nettype wire

// ==== rtl/wb_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

// Wishbone pipelined target, one access per strobe
module wb_sram #(
    parameter int WB_DATA_WIDTH = spi_bridge_pkg::WB_DATA_WIDTH_DEF,
    parameter int WB_ADDR_WIDTH = spi_bridge_pkg::WB_ADDR_WIDTH_DEF
) (
    input  logic                     spi_cs_ni,  // System clock
    input  logic                     spi_sck_i,  // Async reset, active high
    input  logic [WB_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic [WB_DATA_WIDTH-1:0] wb_data_i,  // Write data
    output logic [WB_DATA_WIDTH-1:0] wb_data_o,  // Read data, valid with ack
    input  logic                     wb_we_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    output logic                     wb_ack_o
);

    localparam int DEPTH = 2 ** WB_ADDR_WIDTH;

    logic [WB_DATA_WIDTH-1:0] mem [DEPTH];  // Byte-wide system memory
    logic                     req;          // Strobe accepted this cycle

    assign req = wb_cyc_i & wb_stb_i;

    // Memory array and read port
    always_ff @(posedge spi_cs_ni) begin
        if (req) begin
            if (wb_we_i) begin
                mem[wb_addr_i] <= wb_data_i;
            end
            wb_data_o <= mem[wb_addr_i];    // Old contents on a write, unused by master
        end
    end

    // Ack one cycle after each strobe
    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req;
        end
    end

    // Ack answers the strobe before it while the master still holds the cycle open
    assert property (@(posedge spi_cs_ni) disable iff (spi_sck_i)
        wb_ack_o |-> wb_cyc_i);

endmodule

`default_nettype wire

// ==== rtl/spi_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_bridge_top #(
    parameter int WB_DATA_WIDTH = spi_bridge_pkg::WB_DATA_WIDTH_DEF,
    parameter int WB_ADDR_WIDTH = spi_bridge_pkg::WB_ADDR_WIDTH_DEF
) (
    input  logic spi_cs_ni,     // System clock
    input  logic spi_sck_i,     // Async reset, active high
    input  logic mcu_cs_ni,     // Host chip select
    input  logic mcu_sck_i,     // Host serial clock
    input  logic mcu_sdi_i,     // Host to bridge
    output logic mcu_sdo_o,     // Bridge to host
    output logic stall_o        // Bridge busy
);

    // Wishbone between bridge and memory
    logic [WB_ADDR_WIDTH-1:0] wb_addr;
    logic [WB_DATA_WIDTH-1:0] wb_wdata;
    logic [WB_DATA_WIDTH-1:0] wb_rdata;
    logic                     wb_we;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_ack;

    spi_bus_controller #(
        .WB_DATA_WIDTH(WB_DATA_WIDTH),
        .WB_ADDR_WIDTH(WB_ADDR_WIDTH)
    ) spi_bus_controller_inst (
        .spi_cs_ni(spi_cs_ni),
        .spi_sck_i(spi_sck_i),
        .mcu_cs_ni(mcu_cs_ni),
        .mcu_sck_i(mcu_sck_i),
        .mcu_sdi_i(mcu_sdi_i),
        .mcu_sdo_o(mcu_sdo_o),
        .stall_o  (stall_o),
        .wb_addr_o(wb_addr),
        .wb_data_o(wb_wdata),
        .wb_data_i(wb_rdata),
        .wb_we_o  (wb_we),
        .wb_cyc_o (wb_cyc),
        .wb_stb_o (wb_stb),
        .wb_ack_i (wb_ack)
    );

    wb_sram #(
        .WB_DATA_WIDTH(WB_DATA_WIDTH),
        .WB_ADDR_WIDTH(WB_ADDR_WIDTH)
    ) wb_sram_inst (
        .spi_cs_ni(spi_cs_ni),
        .spi_sck_i(spi_sck_i),
        .wb_addr_i(wb_addr),
        .wb_data_i(wb_wdata),
        .wb_data_o(wb_rdata),
        .wb_we_i  (wb_we),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_ack_o (wb_ack)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_spi_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spi_bridge;

    localparam int DATA_W        = 8;
    localparam int ADDR_W        = 20;
    localparam int CLK_PERIOD    = 100;     // System clock in ns
    localparam int DRIVE_DELAY   = 1;       // Inputs change just after the rising edge
    localparam int SCK_HALF      = 4;       // System cycles per SCK half period, 800 ns SCK
    localparam int CS_IDLE       = 8;       // Cycles CS stays high between transfers
    localparam int STALL_TIMEOUT = 64;      // Cycles allowed for the bridge to go idle
    localparam int SEED          = 30;

    logic spi_cs_ni = 1'b0;     // System clock
    logic spi_sck_i;            // System reset
    logic mcu_cs_ni;
    logic mcu_sck_i;
    logic mcu_sdi_i;
    logic mcu_sdo_o;
    logic stall_o;

    logic [7:0]  tx_buf [0:3];                  // Bytes for the next transfer
    logic [7:0]  model_mem [0:(1<<ADDR_W)-1];   // Expected memory contents
    logic [19:0] model_addr;                    // Address the bridge will auto-increment from

    spi_bridge_top #(
        .WB_DATA_WIDTH(DATA_W),
        .WB_ADDR_WIDTH(ADDR_W)
    ) spi_bridge_top_inst (
        .spi_cs_ni(spi_cs_ni),
        .spi_sck_i(spi_sck_i),
        .mcu_cs_ni(mcu_cs_ni),
        .mcu_sck_i(mcu_sck_i),
        .mcu_sdi_i(mcu_sdi_i),
        .mcu_sdo_o(mcu_sdo_o),
        .stall_o  (stall_o)
    );

    always #(CLK_PERIOD / 2) spi_cs_ni = ~spi_cs_ni;

    // Advance n system cycles and land just after the edge
    task automatic step_clocks(input int n);
        repeat (n) @(posedge spi_cs_ni);
        #DRIVE_DELAY;
    endtask

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
            stop_on_failure();
        end
    endtask

    // Poll stall_o until the bridge is idle
    task automatic wait_stall_low(input string what);
        int cycles;
        cycles = 0;
        while (stall_o !== 1'b0) begin
            if (cycles >= STALL_TIMEOUT) begin
                $display("Timeout at %0t ns: bridge still stalled %s", $time, what);
                stop_on_failure();
            end
            step_clocks(1);
            cycles++;
        end
    endtask

    // Mode 0 host, MSB first, returns the first byte shifted out by the bridge
    task automatic spi_transfer(input int n_bytes, input bit complete,
                                output logic [7:0] first_rx);
        int i;
        int b;
        first_rx = 8'h00;
        wait_stall_low("before the transfer");
        mcu_cs_ni = 1'b0;
        for (i = 0; i < n_bytes; i++) begin
            for (b = 7; b >= 0; b--) begin
                mcu_sdi_i = tx_buf[i][b];   // Changes with the falling edge
                step_clocks(SCK_HALF);
                if (i == 0) begin
                    first_rx = {first_rx[6:0], mcu_sdo_o};  // Sampled at the rising edge
                end
                mcu_sck_i = 1'b1;
                step_clocks(SCK_HALF);
                mcu_sck_i = 1'b0;
            end
        end
        if (complete) begin
            // Valid pulse, strobe and ack still in flight four cycles after the last edge
            check_value("stall_o after last byte", stall_o, 1'b1);
            wait_stall_low("after a complete command");
        end
        mcu_cs_ni = 1'b1;
        mcu_sdi_i = 1'b0;
        step_clocks(CS_IDLE);
    endtask

    task automatic write_addr(input logic [19:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        tx_buf[0] = {1'b1, 1'b1, 2'b00, addr[19:16]};   // Write, address follows
        tx_buf[1] = addr[15:8];
        tx_buf[2] = addr[7:0];
        tx_buf[3] = data;
        spi_transfer(4, 1'b1, unused);
        model_addr = addr;
        model_mem[addr] = data;
    endtask

    task automatic write_next(input logic [7:0] data);
        logic [7:0] unused;
        tx_buf[0] = 8'h80;          // Write at previous address plus one
        tx_buf[1] = data;
        spi_transfer(2, 1'b1, unused);
        model_addr = model_addr + 20'd1;
        model_mem[model_addr] = data;
    endtask

    task automatic read_addr(input logic [19:0] addr);
        logic [7:0] unused;
        tx_buf[0] = {1'b0, 1'b1, 2'b00, addr[19:16]};
        tx_buf[1] = addr[15:8];
        tx_buf[2] = addr[7:0];
        spi_transfer(3, 1'b1, unused);
        model_addr = addr;
    endtask

    // Auto-increment read, first byte out is the previous read result
    task automatic read_next(output logic [7:0] first_rx);
        tx_buf[0] = 8'h00;
        spi_transfer(1, 1'b1, first_rx);
        model_addr = model_addr + 20'd1;
    endtask

    task automatic test_reset_state();
        check_value("stall_o after reset", stall_o, 1'b0);
        check_value("mcu_sdo_o after reset", mcu_sdo_o, 1'b0);
    endtask

    task automatic test_write_read();
        logic [7:0] got;
        write_addr(20'h01234, 8'($urandom));
        read_addr(20'h01234);
        read_next(got);
        check_value("read byte @ 0x01234", got, model_mem[20'h01234]);
    endtask

    task automatic test_auto_increment();
        logic [19:0] base;
        logic [7:0]  got;
        int          i;
        base = 20'h02FFE;           // Run crosses the byte boundary
        write_addr(base, 8'($urandom));
        for (i = 0; i < 3; i++) begin
            write_next(8'($urandom));
        end
        read_addr(base);
        for (i = 0; i < 4; i++) begin
            read_next(got);
            check_value($sformatf("read byte @ 0x%05h", base + 20'(i)), got,
                        model_mem[base + 20'(i)]);
        end
    endtask

    task automatic test_upper_addr();
        logic [7:0] d_lo;
        logic [7:0] d_hi;
        logic [7:0] got;
        d_lo = 8'($urandom);
        d_hi = 8'($urandom);
        if (d_hi == d_lo) begin
            d_hi = ~d_lo;           // Aliasing must show as a mismatch
        end
        write_addr(20'h35678, d_lo);
        write_addr(20'hA5678, d_hi);
        read_addr(20'h35678);
        read_next(got);
        check_value("read byte @ 0x35678", got, model_mem[20'h35678]);
        read_addr(20'hA5678);
        read_next(got);
        check_value("read byte @ 0xA5678", got, model_mem[20'hA5678]);
    endtask

    task automatic test_abort();
        logic [7:0] got;
        // Data register and low address byte now aim a stray write at 0x01234
        write_addr(20'h00034, ~model_mem[20'h01234]);
        tx_buf[0] = 8'hC0;          // Write to 0x01234, cut short after the high address byte
        tx_buf[1] = 8'h12;
        spi_transfer(2, 1'b0, got);
        check_value("stall_o after abort", stall_o, 1'b0);
        read_addr(20'h01234);
        read_next(got);
        check_value("read byte @ 0x01234 after abort", got, model_mem[20'h01234]);
    endtask

    initial begin
        void'($urandom(SEED));
        spi_sck_i  = 1'b1;
        mcu_cs_ni  = 1'b0;
        mcu_sck_i  = 1'b0;
        mcu_sdi_i  = 1'b0;
        model_addr = '0;
        step_clocks(1);
        mcu_cs_ni = 1'b1;           // Clean rising edge clears the shifter count and decoder
        step_clocks(2);
        spi_sck_i = 1'b0;           // Reset held for 3 cycles
        step_clocks(2);

        test_reset_state();
        test_write_read();
        test_auto_increment();
        test_upper_addr();
        test_abort();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/spi_bridge_pkg.sv
rtl/sync2_edge_detect.sv
rtl/spi_byte_shifter.sv
rtl/spi_bus_controller.sv
rtl/wb_sram.sv
rtl/spi_bridge_top.sv
testbench/tb_spi_bridge.sv
